// ==== gameport_consts.svh ====
// game port constants: axis count, count width, tick scale, button bits, sweep end

`ifndef GAMEPORT_CONSTS_SVH
`define GAMEPORT_CONSTS_SVH

// number of analog axis one-shots on the port
`define GP_AXIS_COUNT 4

// width of the sweep count and of each axis threshold
`define GP_CNT_W 8

// low divider bits always counted, step period is (divider+1)*16
`define GP_TICK_BITS 4

// sweep count value that marks an idle sweep
`define GP_SWEEP_END {`GP_CNT_W{1'b1}}

// button positions inside a digital joystick word
`define GP_BTN_LO 4
`define GP_BTN_HI 5

`endif

// ==== joystick_pkg.sv ====
// joystick_pkg: host-side joystick word types and cpu speed option type

`default_nettype none

package joystick_pkg;

	// digital joystick word, buttons at bits 5 and 4
	typedef logic [7:0] joy_digital_t;

	// analog word, X in high byte and Y in low byte
	// both axes are signed bytes, centre is 0
	typedef logic [15:0] joy_analog_t;

	// cpu speed option from the menu
	// 0 max, then /2 /3 /4 /8 /16 /32
	typedef logic [2:0] speed_sel_t;

endpackage

`default_nettype wire

// ==== gameport_pkg.sv ====
// gameport_pkg: sweep count, speed divider, port byte, axis vector and sweep state types

`default_nettype none

`include "gameport_consts.svh"

package gameport_pkg;

	// sweep count, also used for axis thresholds
	typedef logic [`GP_CNT_W-1:0] sweep_cnt_t;

	// decoded speed divider
	typedef logic [4:0] tick_div_t;

	// byte the cpu reads from the game port
	typedef logic [7:0] port_byte_t;

	// one bit per axis one-shot
	typedef logic [`GP_AXIS_COUNT-1:0] axis_vec_t;

	typedef enum logic {
		SWEEP_IDLE,
		SWEEP_RUN
	} sweep_state_t;

endpackage

`default_nettype wire

// ==== gameport_sweep.sv ====
// gameport_sweep: speed decode, tick divider, sweep counter and per-axis thresholds

`default_nettype none

`include "gameport_consts.svh"

module gameport_sweep (
	input  wire                       clk_cpu,
	input  wire                       reset_i,
	input  wire joystick_pkg::speed_sel_t  speed_sel_i,
	input  wire                       joyswap_i,
	input  wire joystick_pkg::joy_analog_t joystick_analog_0_i,
	input  wire joystick_pkg::joy_analog_t joystick_analog_1_i,
	input  wire                       gpio_wr_i,
	output logic                      sweep_start_o,
	output logic                      sweep_run_o,
	output gameport_pkg::sweep_cnt_t  sweep_cnt_o,
	output gameport_pkg::sweep_cnt_t  thr0_o,
	output gameport_pkg::sweep_cnt_t  thr1_o,
	output gameport_pkg::sweep_cnt_t  thr2_o,
	output gameport_pkg::sweep_cnt_t  thr3_o
);

	// signed byte to offset binary
	function automatic gameport_pkg::sweep_cnt_t offset_bin(input logic [`GP_CNT_W-1:0] b);
		return {~b[`GP_CNT_W-1], b[`GP_CNT_W-2:0]};
	endfunction

	gameport_pkg::tick_div_t    tick_div;
	gameport_pkg::sweep_state_t state;
	gameport_pkg::sweep_cnt_t   cnt;
	gameport_pkg::sweep_cnt_t   cnt_next;
	logic [$bits(gameport_pkg::tick_div_t)+`GP_TICK_BITS-1:0] div_cnt;
	logic [$bits(gameport_pkg::tick_div_t)+`GP_TICK_BITS-1:0] div_wrap;
	joystick_pkg::joy_analog_t  joy0_a;
	joystick_pkg::joy_analog_t  joy1_a;

	// speed option to divider, same table as the cpu clock enable
	always_comb begin
		case (speed_sel_i)
			3'd1: tick_div = 5'd1;
			3'd2: tick_div = 5'd2;
			3'd3: tick_div = 5'd3;
			3'd4: tick_div = 5'd7;
			3'd5: tick_div = 5'd15;
			3'd6: tick_div = 5'd31;
			default: tick_div = 5'd0;
		endcase
	end

	// divider wraps after (div+1)*16 cycles
	assign div_wrap = {tick_div, {`GP_TICK_BITS{1'b1}}};
	assign cnt_next = cnt + 1'b1;

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			state <= gameport_pkg::SWEEP_IDLE;
			cnt <= `GP_SWEEP_END;
			div_cnt <= '0;
			sweep_start_o <= 1'b0;
		end else begin
			sweep_start_o <= gpio_wr_i;
			if (gpio_wr_i) begin
				// a write restarts the sweep even mid-run
				state <= gameport_pkg::SWEEP_RUN;
				cnt <= '0;
				div_cnt <= '0;
			end else if (state == gameport_pkg::SWEEP_RUN) begin
				if (div_cnt == div_wrap) begin
					div_cnt <= '0;
					cnt <= cnt_next;
					// back to idle on the edge the count hits the end value
					if (cnt_next == `GP_SWEEP_END) begin
						state <= gameport_pkg::SWEEP_IDLE;
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	assign sweep_run_o = (state == gameport_pkg::SWEEP_RUN);
	assign sweep_cnt_o = cnt;

	// swap exchanges the whole joysticks
	assign joy0_a = joyswap_i ? joystick_analog_1_i : joystick_analog_0_i;
	assign joy1_a = joyswap_i ? joystick_analog_0_i : joystick_analog_1_i;

	// axes 0/1 are joystick 1 X/Y, axes 2/3 are joystick 0 X/Y
	assign thr0_o = offset_bin(joy1_a[15:8]);
	assign thr1_o = offset_bin(joy1_a[7:0]);
	assign thr2_o = offset_bin(joy0_a[15:8]);
	assign thr3_o = offset_bin(joy0_a[7:0]);

endmodule

`default_nettype wire

// ==== gameport_axis.sv ====
// gameport_axis: one game port axis one-shot timed against the shared sweep count

`default_nettype none

module gameport_axis (
	input  wire                           clk_cpu,
	input  wire                           reset_i,
	input  wire                           sweep_start_i,
	input  wire                           sweep_run_i,
	input  wire gameport_pkg::sweep_cnt_t sweep_cnt_i,
	input  wire gameport_pkg::sweep_cnt_t thr_i,
	output logic                          axis_o
);

	logic axis_q;
	logic thr_hit;
	logic axis_clr;

	// count reached this axis position
	assign thr_hit = (sweep_cnt_i == thr_i);

	// also drop the bit once the sweep is over
	assign axis_clr = thr_hit | ~sweep_run_i;

	// pulse width follows stick position
	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			axis_q <= 1'b0;
		end else if (sweep_start_i) begin
			// start wins over a match on count 0
			axis_q <= 1'b1;
		end else if (axis_clr) begin
			axis_q <= 1'b0;
		end
	end

	assign axis_o = axis_q;

endmodule

`default_nettype wire

// ==== gameport_byte.sv ====
// gameport_byte: button swap and inversion, and packing of axis and button bits

`default_nettype none

`include "gameport_consts.svh"

module gameport_byte (
	input  wire                             clk_cpu,
	input  wire                             reset_i,
	input  wire                             joyswap_i,
	input  wire joystick_pkg::joy_digital_t joystick_0_i,
	input  wire joystick_pkg::joy_digital_t joystick_1_i,
	input  wire gameport_pkg::axis_vec_t    axis_i,
	output gameport_pkg::port_byte_t        joy_o
);

	logic [1:0] btn0;
	logic [1:0] btn1;
	logic [3:0] btn_next;
	logic [3:0] btn_q;

	// buttons 5,4 of each stick
	assign btn0 = joystick_0_i[`GP_BTN_HI:`GP_BTN_LO];
	assign btn1 = joystick_1_i[`GP_BTN_HI:`GP_BTN_LO];

	// port buttons are active low
	assign btn_next = joyswap_i ? ~{btn1, btn0} : ~{btn0, btn1};

	// released buttons read as 1 out of reset
	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			btn_q <= 4'hF;
		end else begin
			btn_q <= btn_next;
		end
	end

	// buttons high nibble, axis one-shots low nibble
	assign joy_o = {btn_q, axis_i};

endmodule

`default_nettype wire

// ==== gameport_top.sv ====
// gameport_top: game port top with sweep, four axis timers and port byte packer

`default_nettype none

`include "gameport_consts.svh"

module gameport_top (
	input  wire                             clk_cpu,
	input  wire                             reset_i,
	input  wire joystick_pkg::speed_sel_t   speed_sel_i,
	input  wire                             joyswap_i,
	input  wire joystick_pkg::joy_digital_t joystick_0_i,
	input  wire joystick_pkg::joy_digital_t joystick_1_i,
	input  wire joystick_pkg::joy_analog_t  joystick_analog_0_i,
	input  wire joystick_pkg::joy_analog_t  joystick_analog_1_i,
	input  wire                             gpio_wr_i,
	output gameport_pkg::port_byte_t        joy_o
);

	wire                           sweep_start;
	wire                           sweep_run;
	wire gameport_pkg::sweep_cnt_t sweep_cnt;
	wire gameport_pkg::sweep_cnt_t thr [`GP_AXIS_COUNT];
	wire gameport_pkg::axis_vec_t  axis_bits;

	gameport_sweep sweep0 (
		.clk_cpu             ( clk_cpu             ),
		.reset_i             ( reset_i             ),
		.speed_sel_i         ( speed_sel_i         ),
		.joyswap_i           ( joyswap_i           ),
		.joystick_analog_0_i ( joystick_analog_0_i ),
		.joystick_analog_1_i ( joystick_analog_1_i ),
		.gpio_wr_i           ( gpio_wr_i           ),
		.sweep_start_o       ( sweep_start         ),
		.sweep_run_o         ( sweep_run           ),
		.sweep_cnt_o         ( sweep_cnt           ),
		.thr0_o              ( thr[0]              ),
		.thr1_o              ( thr[1]              ),
		.thr2_o              ( thr[2]              ),
		.thr3_o              ( thr[3]              )
	);

	// one one-shot per axis, all on the shared sweep
	for (genvar i = 0; i < `GP_AXIS_COUNT; i++) begin : g_axis
		gameport_axis axis0 (
			.clk_cpu       ( clk_cpu      ),
			.reset_i       ( reset_i      ),
			.sweep_start_i ( sweep_start  ),
			.sweep_run_i   ( sweep_run    ),
			.sweep_cnt_i   ( sweep_cnt    ),
			.thr_i         ( thr[i]       ),
			.axis_o        ( axis_bits[i] )
		);
	end

	gameport_byte byte0 (
		.clk_cpu      ( clk_cpu      ),
		.reset_i      ( reset_i      ),
		.joyswap_i    ( joyswap_i    ),
		.joystick_0_i ( joystick_0_i ),
		.joystick_1_i ( joystick_1_i ),
		.axis_i       ( axis_bits    ),
		.joy_o        ( joy_o        )
	);

endmodule

`default_nettype wire

// ==== tb_gameport.sv ====
// tb_gameport: clock, reset, LFSR stimulus, reference model, assertions, watchdog and summary

`default_nettype none

`include "gameport_consts.svh"

module tb_gameport;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_SWEEPS = 10;
	localparam int SWEEP_STEPS = 256;
	localparam int MAX_PERIOD = 32;
	localparam int MARGIN_CYCLES = 4000;
	localparam int WATCHDOG_TIME =
		(NUM_SWEEPS * SWEEP_STEPS * MAX_PERIOD + MARGIN_CYCLES) * CLK_PERIOD;

	logic                       clk_cpu;
	logic                       reset_i;
	joystick_pkg::speed_sel_t   speed_sel_i;
	logic                       joyswap_i;
	joystick_pkg::joy_digital_t joystick_0_i;
	joystick_pkg::joy_digital_t joystick_1_i;
	joystick_pkg::joy_analog_t  joystick_analog_0_i;
	joystick_pkg::joy_analog_t  joystick_analog_1_i;
	logic                       gpio_wr_i;
	gameport_pkg::port_byte_t   joy_o;

	logic [31:0] lfsr_q;
	logic        sweep_live;
	int          checks;
	int          value_errs;
	int          timing_errs;
	int          idle_errs;

	gameport_top dut0 (
		.clk_cpu             ( clk_cpu             ),
		.reset_i             ( reset_i             ),
		.speed_sel_i         ( speed_sel_i         ),
		.joyswap_i           ( joyswap_i           ),
		.joystick_0_i        ( joystick_0_i        ),
		.joystick_1_i        ( joystick_1_i        ),
		.joystick_analog_0_i ( joystick_analog_0_i ),
		.joystick_analog_1_i ( joystick_analog_1_i ),
		.gpio_wr_i           ( gpio_wr_i           ),
		.joy_o               ( joy_o               )
	);

	initial begin
		clk_cpu = 1'b0;
		forever #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: tests still running after %0d time units", WATCHDOG_TIME);
		$display("Testbench failed");
		$finish;
	end

	task automatic idle_axis_error();
		idle_errs++;
		$display("axis bits were high at %0t while no sweep had been started", $time);
	endtask

	// axis bits may only be high while a sweep is in flight
	idle_axis_check: assert property (@(posedge clk_cpu) disable iff (reset_i)
		(joy_o[3:0] == 4'h0) || sweep_live)
		else idle_axis_error();

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic joystick_pkg::joy_analog_t rand_analog();
		logic [31:0] v;
		v = take_bits(16);
		return v[15:0];
	endfunction

	function automatic joystick_pkg::joy_digital_t rand_digital();
		logic [31:0] v;
		v = take_bits(8);
		return v[7:0];
	endfunction

	// cycles per sweep step for a speed option
	function automatic int step_period(input joystick_pkg::speed_sel_t sel);
		int div;
		case (sel)
			3'd1: div = 1;
			3'd2: div = 2;
			3'd3: div = 3;
			3'd4: div = 7;
			3'd5: div = 15;
			3'd6: div = 31;
			default: div = 0;
		endcase
		return (div + 1) * 16;
	endfunction

	// axes 0/1 read joystick 1 X/Y, axes 2/3 joystick 0 X/Y, after the swap
	function automatic int axis_threshold(input joystick_pkg::joy_analog_t a0, a1,
		input logic swap, input int idx);
		joystick_pkg::joy_analog_t stick;
		logic signed [7:0]         pos;
		if (idx < 2) begin
			stick = swap ? a0 : a1;
		end else begin
			stick = swap ? a1 : a0;
		end
		pos = (idx % 2 == 0) ? stick[15:8] : stick[7:0];
		// signed position moved up into 0..255
		return int'(pos) + 128;
	endfunction

	// active low buttons, first stick in the upper pair
	function automatic logic [3:0] expected_buttons(input joystick_pkg::joy_digital_t d0, d1,
		input logic swap);
		logic [1:0] first;
		logic [1:0] second;
		first = swap ? d1[`GP_BTN_HI:`GP_BTN_LO] : d0[`GP_BTN_HI:`GP_BTN_LO];
		second = swap ? d0[`GP_BTN_HI:`GP_BTN_LO] : d1[`GP_BTN_HI:`GP_BTN_LO];
		return ~{first, second};
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		value_errs++;
		$display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp_v, act_v, $time);
	endtask

	task automatic report_fall(input int idx, input int seen, input int lo, input int hi);
		timing_errs++;
		if (seen < 0) begin
			$display("axis %0d never went low, expected it %0d to %0d cycles after the write",
				idx, lo, hi);
		end else begin
			$display("axis %0d went low %0d cycles after the write, expected %0d to %0d",
				idx, seen, lo, hi);
		end
	endtask

	task automatic check_buttons(input joystick_pkg::joy_digital_t d0, d1, input logic swap);
		logic [3:0] exp_nib;
		exp_nib = expected_buttons(d0, d1, swap);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		joystick_0_i = d0;
		joystick_1_i = d1;
		joyswap_i = swap;
		// buttons are registered once
		@(posedge clk_cpu);
		@(negedge clk_cpu);
		checks++;
		assert (joy_o[7:4] == exp_nib) else report_value("joy_o[7:4]", exp_nib, joy_o[7:4]);
	endtask

	// one-cycle write pulse, returns just after the edge that takes it
	task automatic start_write(input joystick_pkg::speed_sel_t sel, input logic swap,
		input joystick_pkg::joy_analog_t a0, a1, input joystick_pkg::joy_digital_t d0, d1);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		speed_sel_i = sel;
		joyswap_i = swap;
		joystick_analog_0_i = a0;
		joystick_analog_1_i = a1;
		joystick_0_i = d0;
		joystick_1_i = d1;
		gpio_wr_i = 1'b1;
		sweep_live = 1'b1;
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		gpio_wr_i = 1'b0;
	endtask

	task automatic run_sweep(input joystick_pkg::speed_sel_t sel, input logic swap,
		input joystick_pkg::joy_analog_t a0, a1, input joystick_pkg::joy_digital_t d0, d1);
		int         period;
		int         limit;
		int         thr [`GP_AXIS_COUNT];
		int         fall [`GP_AXIS_COUNT];
		int         lo;
		int         hi;
		logic [3:0] exp_nib;
		period = step_period(sel);
		limit = SWEEP_STEPS * period + 3;
		exp_nib = expected_buttons(d0, d1, swap);
		for (int i = 0; i < `GP_AXIS_COUNT; i++) begin
			thr[i] = axis_threshold(a0, a1, swap, i);
			fall[i] = -1;
		end
		start_write(sel, swap, a0, a1, d0, d1);
		// r counts edges after the one that took the write
		@(negedge clk_cpu);
		for (int r = 1; r <= limit; r++) begin
			@(negedge clk_cpu);
			checks++;
			assert (joy_o[7:4] == exp_nib) else report_value("joy_o[7:4]", exp_nib, joy_o[7:4]);
			if (r == 1) begin
				assert (joy_o[3:0] == 4'hF) else report_value("joy_o[3:0]", 4'hF, joy_o[3:0]);
			end else begin
				for (int i = 0; i < `GP_AXIS_COUNT; i++) begin
					if (fall[i] < 0) begin
						if (!joy_o[i]) begin
							fall[i] = r;
						end
					end else begin
						// once low, stays low for the rest of the sweep
						assert (!joy_o[i])
							else report_value($sformatf("joy_o[%0d]", i), 0, joy_o[i]);
					end
				end
			end
		end
		assert (joy_o[3:0] == 4'h0) else report_value("joy_o[3:0]", 4'h0, joy_o[3:0]);
		for (int i = 0; i < `GP_AXIS_COUNT; i++) begin
			lo = thr[i] * period + 1;
			hi = lo + 2;
			checks++;
			assert (fall[i] >= lo && fall[i] <= hi) else report_fall(i, fall[i], lo, hi);
		end
		sweep_live = 1'b0;
	endtask

	initial begin
		joystick_pkg::joy_digital_t d0;
		joystick_pkg::joy_digital_t d1;
		reset_i = 1'b1;
		speed_sel_i = 3'd0;
		joyswap_i = 1'b0;
		joystick_0_i = 8'h00;
		joystick_1_i = 8'h00;
		joystick_analog_0_i = 16'h0000;
		joystick_analog_1_i = 16'h0000;
		gpio_wr_i = 1'b0;
		sweep_live = 1'b0;
		lfsr_q = 32'h0210_e034;
		checks = 0;
		value_errs = 0;
		timing_errs = 0;
		idle_errs = 0;

		repeat (RESET_CYCLES) @(posedge clk_cpu);
		#DRIVE_DELAY;
		reset_i = 1'b0;

		// idle port after reset, buttons released
		repeat (20) begin
			@(negedge clk_cpu);
			checks++;
			assert (joy_o == 8'hF0) else report_value("joy_o", 8'hF0, joy_o);
		end

		// button nibble, both swap settings
		for (int k = 0; k < 16; k++) begin
			d0 = rand_digital();
			d1 = rand_digital();
			check_buttons(d0, d1, k[0]);
		end

		// speed 0, joystick 1 at both ends of its range
		run_sweep(3'd0, 1'b0, rand_analog(), 16'h807F, rand_digital(), rand_digital());
		run_sweep(3'd0, 1'b0, rand_analog(), rand_analog(), rand_digital(), rand_digital());
		run_sweep(3'd0, 1'b0, rand_analog(), rand_analog(), rand_digital(), rand_digital());

		// swapped sticks
		run_sweep(3'd0, 1'b1, 16'h7F80, rand_analog(), rand_digital(), rand_digital());
		run_sweep(3'd0, 1'b1, rand_analog(), rand_analog(), rand_digital(), rand_digital());

		// slower steps, and selection 7 back to the fastest
		run_sweep(3'd1, 1'b0, rand_analog(), rand_analog(), rand_digital(), rand_digital());
		run_sweep(3'd1, 1'b1, rand_analog(), rand_analog(), rand_digital(), rand_digital());
		run_sweep(3'd7, 1'b0, rand_analog(), rand_analog(), rand_digital(), rand_digital());

		// restart mid-sweep, first sweep drops every axis at once
		d0 = rand_digital();
		d1 = rand_digital();
		start_write(3'd0, 1'b0, 16'h8080, 16'h8080, d0, d1);
		repeat (40 * 16) @(posedge clk_cpu);
		run_sweep(3'd0, 1'b0, rand_analog(), rand_analog(), rand_digital(), rand_digital());

		repeat (4) @(posedge clk_cpu);
		$display("summary: %0d checks, %0d value errors, %0d timing errors, %0d idle axis errors",
			checks, value_errs, timing_errs, idle_errs);
		if (value_errs == 0 && timing_errs == 0 && idle_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
joystick_pkg.sv
gameport_pkg.sv
gameport_sweep.sv
gameport_axis.sv
gameport_byte.sv
gameport_top.sv
tb_gameport.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the game port testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gameport -f build.f -o sim_gameport > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build did not complete"; exit 1; }

./obj_dir/sim_gameport > sim.log 2>&1
cat sim.log

# the log decides the result
grep -q "Testbench failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation ended without a result line"; exit 1; }
exit 0
